/* logic/cmd_params.svh */
`ifndef CMD_PARAMS_SVH
`define CMD_PARAMS_SVH

`define CMD_NGPIO 8
`define CMD_VERSION 32'd2100

`define CMD_MAX_ARGS 4 // argument slots held by dispatch
`define CMD_MAX_PARAMS 4 // response words per message

// --------------------
`define CMD_GET_VERSION 5'd0
`define CMD_GET_TIME 5'd2
`define CMD_SET_DIGITAL_OUT 5'd15
`define CMD_SHUTDOWN 5'd19

`define RSP_GET_VERSION 32'd0
`define RSP_GET_TIME 32'd1

`endif

/* logic/cmd_pkg.sv */
`include "cmd_params.svh"

package cmd_pkg;

	typedef logic [7:0] msg_byte_t;
	typedef logic signed [31:0] arg_word_t;
	typedef logic [4:0] cmd_id_t;
	typedef logic [1:0] arg_idx_t;
	typedef logic [7:0] rsp_len_t;
	typedef logic [`CMD_NGPIO-1:0] gpio_t;

	typedef enum logic [1:0] {unit_none, unit_system, unit_gpio} unit_id_t;

	typedef struct packed {
		unit_id_t unit;
		arg_idx_t nargs;
		logic has_response;
	} cmd_entry_t;

	typedef struct packed {
		logic start; // one cycle on the selected unit
		cmd_id_t cmd;
		arg_word_t arg; // current argument word
	} unit_req_t;

	typedef struct packed {
		logic arg_advance;
		logic param_write;
		logic done;
		arg_word_t param;
	} unit_rsp_t;

	typedef enum logic [2:0] {dec_idle, dec_arg_first, dec_arg_cont, dec_arg_end, dec_hold} dec_state_t;
	typedef enum logic [2:0] {enc_idle, enc_load, enc_trim, enc_send, enc_post} enc_state_t;

	// fixed command table, ids without a unit are consumed and dropped
	function automatic cmd_entry_t cmd_lookup(cmd_id_t id);
		case (id)
			`CMD_GET_VERSION: return '{unit: unit_system, nargs: 2'd0, has_response: 1'b1};
			`CMD_GET_TIME: return '{unit: unit_system, nargs: 2'd0, has_response: 1'b1};
			`CMD_SET_DIGITAL_OUT: return '{unit: unit_gpio, nargs: 2'd2, has_response: 1'b0};
			`CMD_SHUTDOWN: return '{unit: unit_system, nargs: 2'd0, has_response: 1'b0};
			default: return '{unit: unit_none, nargs: 2'd0, has_response: 1'b0};
		endcase
	endfunction

endpackage

/* logic/vlq_decoder.sv */
`include "cmd_params.svh"

module vlq_decoder
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input msg_byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	input logic dispatch_busy,
	output logic cmd_valid,
	output cmd_id_t cmd_id,
	output logic arg_valid,
	output arg_word_t arg_word,
	output arg_idx_t arg_idx
);

	dec_state_t state;
	cmd_entry_t entry;
	arg_idx_t nargs;
	logic take;

	assign take = msg_ready && !msg_rd_en; // read pulse, then one gap cycle
	// ids above 31 fall outside the table
	assign entry = (msg_data[7:5] == 3'b000) ? cmd_lookup(msg_data[4:0]) : '0;
	assign arg_valid = (state == dec_arg_end);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dec_idle;
			msg_rd_en <= 1'b0;
			cmd_valid <= 1'b0;
			cmd_id <= '0;
			nargs <= '0;
			arg_idx <= '0;
		end else begin
			msg_rd_en <= 1'b0;
			cmd_valid <= 1'b0;
			case (state)
				dec_idle: if (take && !dispatch_busy) begin
					msg_rd_en <= 1'b1;
					cmd_id <= msg_data[4:0];
					nargs <= entry.nargs;
					arg_idx <= '0;
					if (entry.nargs == 2'd0) begin
						cmd_valid <= (msg_data[7:5] == 3'b000); // ids above 31 are only consumed
						state <= dec_hold;
					end else begin
						state <= dec_arg_first;
					end
				end
				dec_arg_first, dec_arg_cont: if (take) begin
					msg_rd_en <= 1'b1;
					state <= msg_data[7] ? dec_arg_cont : dec_arg_end; // bit 7 clear ends it
				end
				dec_arg_end: if (arg_idx == nargs - 2'd1) begin
					cmd_valid <= 1'b1;
					state <= dec_hold;
				end else begin
					arg_idx <= arg_idx + 2'd1;
					state <= dec_arg_first;
				end
				dec_hold: if (!cmd_valid && !dispatch_busy)
					state <= dec_idle; // busy only shows a cycle after cmd_valid
				default: state <= dec_idle;
			endcase
		end
	end

	// 7 data bits per byte, 11 in bits 6:5 of the first byte means negative
	always_ff @(posedge clk) begin
		if (state == dec_arg_first && take)
			arg_word <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
		else if (state == dec_arg_cont && take)
			arg_word <= {arg_word[24:0], msg_data[6:0]};
	end

	a_rd_needs_data: assert property (@(posedge clk) disable iff (reset)
		msg_rd_en |-> msg_ready);

endmodule

/* logic/cmd_dispatch.sv */
`include "cmd_params.svh"

module cmd_dispatch
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input cmd_id_t cmd_id,
	input logic arg_valid,
	input arg_word_t arg_word,
	input arg_idx_t arg_idx,
	output logic dispatch_busy,
	output unit_req_t sys_req,
	output unit_req_t gpio_req,
	input unit_rsp_t sys_rsp,
	input unit_rsp_t gpio_rsp,
	output logic rsp_push,
	output arg_word_t rsp_word,
	output logic rsp_end,
	input logic enc_busy
);

	arg_word_t args [`CMD_MAX_ARGS];
	cmd_entry_t entry;
	cmd_id_t cur_cmd;
	arg_word_t cur_arg;
	arg_idx_t arg_ptr;
	logic busy, running, start, launch;
	logic [$clog2(`CMD_MAX_PARAMS):0] push_cnt;
	unit_rsp_t sel_rsp;

	assign dispatch_busy = busy;
	// a unit with a response waits until the encoder is free
	assign launch = busy && !running && !cmd_valid && entry.unit != unit_none
		&& (!entry.has_response || !enc_busy);

	assign sys_req = '{start: start && entry.unit == unit_system, cmd: cur_cmd, arg: cur_arg};
	assign gpio_req = '{start: start && entry.unit == unit_gpio, cmd: cur_cmd, arg: cur_arg};

	always_comb begin
		case (entry.unit)
			unit_system: sel_rsp = sys_rsp;
			unit_gpio: sel_rsp = gpio_rsp;
			default: sel_rsp = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (arg_valid)
			args[arg_idx] <= arg_word;
	end

	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			running <= 1'b0;
			start <= 1'b0;
			rsp_push <= 1'b0;
			rsp_end <= 1'b0;
			push_cnt <= '0;
		end else begin
			start <= launch;
			rsp_push <= running && sel_rsp.param_write && entry.has_response;
			rsp_end <= 1'b0;
			if (cmd_valid)
				busy <= 1'b1;
			else if (busy && !running && entry.unit == unit_none)
				busy <= 1'b0; // no unit, drop it
			if (launch)
				running <= 1'b1;
			if (running && sel_rsp.done) begin
				running <= 1'b0;
				busy <= 1'b0;
				rsp_end <= entry.has_response;
			end
			if (launch)
				push_cnt <= '0;
			else if (rsp_push)
				push_cnt <= push_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		rsp_word <= sel_rsp.param;
		if (cmd_valid) begin
			entry <= cmd_lookup(cmd_id);
			cur_cmd <= cmd_id;
			cur_arg <= args[0];
			arg_ptr <= 2'd1;
		end else if (running && sel_rsp.arg_advance) begin
			cur_arg <= args[arg_ptr]; // valid the cycle after the request
			arg_ptr <= arg_ptr + 2'd1;
		end
	end

	a_push_limit: assert property (@(posedge clk) disable iff (reset)
		rsp_push |-> push_cnt < `CMD_MAX_PARAMS);

endmodule

/* logic/vlq_encoder.sv */
`include "cmd_params.svh"

module vlq_encoder
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic rsp_push,
	input arg_word_t rsp_word,
	input logic rsp_end,
	output logic enc_busy,
	output msg_byte_t send_ring_data,
	output logic send_ring_wr_en,
	input logic send_ring_full,
	output rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en,
	input logic send_fifo_full
);

	localparam int PW = $clog2(`CMD_MAX_PARAMS);

	enc_state_t state;
	arg_word_t words [`CMD_MAX_PARAMS];
	logic [PW:0] wr_ptr, rd_ptr; // extra bit tells full from empty
	logic ended, raw, can_trim;
	logic [34:0] sh; // word sign-extended to five 7-bit groups
	logic [2:0] cnt; // groups left
	rsp_len_t len;
	arg_word_t cur;

	assign cur = words[rd_ptr[PW-1:0]];
	assign can_trim = cnt != 3'd1 && (sh[34:26] == 9'h1ff || sh[34:26] < 9'd3);

	assign send_ring_wr_en = (state == enc_send) && !send_ring_full;
	assign send_ring_data = raw ? sh[7:0] : {cnt != 3'd1, sh[34:28]};
	assign send_fifo_wr_en = (state == enc_post) && !send_fifo_full;
	assign send_fifo_data = len;

	always_ff @(posedge clk) begin
		if (rsp_push)
			words[wr_ptr[PW-1:0]] <= rsp_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= enc_idle;
			wr_ptr <= '0;
			rd_ptr <= '0;
			ended <= 1'b0;
			enc_busy <= 1'b0;
			raw <= 1'b0;
			cnt <= '0;
			len <= '0;
		end else begin
			if (rsp_push) begin
				wr_ptr <= wr_ptr + 1'b1;
				enc_busy <= 1'b1;
			end
			if (rsp_end)
				ended <= 1'b1;
			case (state)
				enc_idle: if (wr_ptr != rd_ptr)
					state <= enc_load;
				else if (ended)
					state <= enc_post;
				enc_load: begin
					raw <= (len == 8'd0); // the response id goes out as one plain byte
					cnt <= (len == 8'd0) ? 3'd1 : 3'd5;
					state <= (len == 8'd0) ? enc_send : enc_trim;
				end
				enc_trim: if (can_trim)
					cnt <= cnt - 3'd1;
				else
					state <= enc_send;
				enc_send: if (!send_ring_full) begin
					len <= len + 8'd1;
					cnt <= cnt - 3'd1;
					if (cnt == 3'd1) begin
						rd_ptr <= rd_ptr + 1'b1;
						state <= enc_idle;
					end
				end
				enc_post: if (!send_fifo_full) begin
					wr_ptr <= '0;
					rd_ptr <= '0;
					ended <= 1'b0;
					enc_busy <= 1'b0;
					len <= '0;
					state <= enc_idle;
				end
				default: state <= enc_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			enc_load: sh <= (len == 8'd0) ? {27'b0, cur[7:0]} : {{3{cur[31]}}, cur};
			enc_trim: if (can_trim) sh <= {sh[27:0], 7'b0};
			enc_send: if (!send_ring_full) sh <= {sh[27:0], 7'b0};
			default: ;
		endcase
	end

	// a full ring stalls the byte in flight without dropping it
	a_ring_stall: assert property (@(posedge clk) disable iff (reset)
		(state == enc_send && send_ring_full) |=> $stable(send_ring_data));

endmodule

/* logic/system_unit.sv */
`include "cmd_params.svh"

module system_unit
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input unit_req_t req,
	output unit_rsp_t rsp,
	input arg_word_t systime,
	output logic shutdown
);

	logic param_write, done, second;
	arg_word_t param, value;

	assign rsp = '{arg_advance: 1'b0, param_write: param_write, done: done, param: param};

	always_ff @(posedge clk) begin
		if (reset) begin
			param_write <= 1'b0;
			done <= 1'b0;
			second <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			param_write <= 1'b0;
			done <= 1'b0;
			second <= 1'b0;
			if (second) begin
				param_write <= 1'b1; // value word ends the command
				done <= 1'b1;
			end else if (req.start) begin
				case (req.cmd)
					`CMD_GET_VERSION, `CMD_GET_TIME: begin
						param_write <= 1'b1;
						second <= 1'b1;
					end
					`CMD_SHUTDOWN: begin
						shutdown <= 1'b1; // held until reset
						done <= 1'b1;
					end
					default: done <= 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (second) begin
			param <= value;
		end else if (req.start) begin
			param <= (req.cmd == `CMD_GET_TIME) ? `RSP_GET_TIME : `RSP_GET_VERSION;
			value <= (req.cmd == `CMD_GET_TIME) ? systime : `CMD_VERSION; // time taken at start
		end
	end

endmodule

/* logic/gpio_unit.sv */
`include "cmd_params.svh"

module gpio_unit
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input unit_req_t req,
	output unit_rsp_t rsp,
	input logic shutdown,
	output gpio_t gpio
);

	localparam int CW = $clog2(`CMD_NGPIO);

	logic take_chan, pending, apply;
	logic [CW-1:0] chan;

	assign take_chan = req.start && req.cmd == `CMD_SET_DIGITAL_OUT;
	// channel arrives with start, value is asked for right away
	assign rsp = '{arg_advance: take_chan, param_write: 1'b0, done: pending, param: '0};

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			apply <= 1'b0;
			gpio <= '0;
		end else begin
			pending <= req.start;
			apply <= take_chan && !req.arg[31] && req.arg < `CMD_NGPIO; // out of range is ignored
			if (shutdown)
				gpio <= '0;
			else if (pending && apply)
				gpio[chan] <= req.arg[0];
		end
	end

	always_ff @(posedge clk) begin
		if (take_chan)
			chan <= req.arg[CW-1:0];
	end

	// shutdown latch holds and the outputs stay low until reset
	a_shutdown_low: assert property (@(posedge clk) disable iff (reset)
		shutdown |=> shutdown && gpio == '0);

endmodule

/* logic/command.sv */
`include "cmd_params.svh"

module command
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input msg_byte_t msg_data,
	input logic msg_ready,
	input logic send_ring_full,
	input logic send_fifo_full,
	output logic msg_rd_en,
	output logic send_ring_wr_en,
	output logic send_fifo_wr_en,
	output msg_byte_t send_ring_data,
	output rsp_len_t send_fifo_data,
	input arg_word_t systime,
	output gpio_t gpio
);

	// --------------------
	logic cmd_valid, arg_valid, dispatch_busy;
	cmd_id_t cmd_id;
	arg_word_t arg_word;
	arg_idx_t arg_idx;
	unit_req_t sys_req, gpio_req;
	unit_rsp_t sys_rsp, gpio_rsp;
	logic rsp_push, rsp_end, enc_busy;
	arg_word_t rsp_word;
	logic shutdown;

	vlq_decoder u_decoder (
		.clk(clk), .reset(reset),
		.msg_data(msg_data), .msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.dispatch_busy(dispatch_busy),
		.cmd_valid(cmd_valid), .cmd_id(cmd_id),
		.arg_valid(arg_valid), .arg_word(arg_word), .arg_idx(arg_idx)
	);

	cmd_dispatch u_dispatch (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_id(cmd_id),
		.arg_valid(arg_valid), .arg_word(arg_word), .arg_idx(arg_idx),
		.dispatch_busy(dispatch_busy),
		.sys_req(sys_req), .gpio_req(gpio_req), .sys_rsp(sys_rsp), .gpio_rsp(gpio_rsp),
		.rsp_push(rsp_push), .rsp_word(rsp_word), .rsp_end(rsp_end), .enc_busy(enc_busy)
	);

	vlq_encoder u_encoder (
		.clk(clk), .reset(reset),
		.rsp_push(rsp_push), .rsp_word(rsp_word), .rsp_end(rsp_end), .enc_busy(enc_busy),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full)
	);

	system_unit u_system (
		.clk(clk), .reset(reset), .req(sys_req), .rsp(sys_rsp),
		.systime(systime), .shutdown(shutdown)
	);

	gpio_unit u_gpio (
		.clk(clk), .reset(reset), .req(gpio_req), .rsp(gpio_rsp),
		.shutdown(shutdown), .gpio(gpio)
	);

endmodule

/* tb/command_checker.sv */
module command_checker
	import cmd_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic msg_ready,
	input logic msg_rd_en,
	input msg_byte_t send_ring_data,
	input logic send_ring_wr_en,
	input logic send_ring_full,
	input rsp_len_t send_fifo_data,
	input logic send_fifo_wr_en,
	input gpio_t gpio
);
	timeunit 1ns;
	timeprecision 1ps;

	msg_byte_t got [$]; // ring bytes of the running test
	rsp_len_t got_len;
	int fifo_writes;
	int tests_run = 0;
	int tests_failed = 0;
	int other_errors = 0;
	logic full_write;
	logic [8*16-1:0] cur_name;
	int cur_nexp;
	logic [47:0] cur_exp; // byte i at bits 8*i+7:8*i
	gpio_t cur_gpio;

	always @(posedge clk) begin
		if (!reset) begin
			if (msg_rd_en && !msg_ready) begin
				$display("the DUT read the input FIFO while it was empty");
				other_errors++;
			end
			if (send_ring_wr_en) begin
				got.push_back(send_ring_data);
				if (send_ring_full)
					full_write = 1'b1;
			end
			if (send_fifo_wr_en) begin
				got_len = send_fifo_data;
				fifo_writes++;
			end
		end
	end

	task automatic start_test(input logic [8*16-1:0] name, input int nexp,
			input logic [47:0] exp_bytes, input gpio_t exp_gpio);
		cur_name = name;
		cur_nexp = nexp;
		cur_exp = exp_bytes;
		cur_gpio = exp_gpio;
		got.delete();
		got_len = '0;
		fifo_writes = 0;
		full_write = 1'b0;
	endtask

	// --------------------
	task automatic finish_test();
		int i, exp_writes;
		logic bad;
		bad = 1'b0;
		exp_writes = (cur_nexp != 0) ? 1 : 0;
		tests_run++;
		if (full_write) begin
			$display("%0s: a ring byte was written while the ring was full", cur_name);
			bad = 1'b1;
		end else if (got.size() != cur_nexp) begin
			$display("FAIL %0s: ring bytes expected %0d actual %0d", cur_name, cur_nexp,
				got.size());
			bad = 1'b1;
		end else if (fifo_writes != exp_writes) begin
			$display("%0s: %0d length writes seen where %0d belong", cur_name, fifo_writes,
				exp_writes);
			bad = 1'b1;
		end else if (cur_nexp != 0 && got_len != cur_nexp) begin
			$display("FAIL %0s: length expected %0d actual %0d", cur_name, cur_nexp, got_len);
			bad = 1'b1;
		end
		for (i = 0; i < cur_nexp && !bad; i++) begin
			if (got[i] !== cur_exp[8*i +: 8]) begin
				$display("FAIL %0s: byte %0d expected %h actual %h", cur_name, i,
					cur_exp[8*i +: 8], got[i]);
				bad = 1'b1;
			end
		end
		if (!bad && gpio !== cur_gpio) begin
			$display("FAIL %0s: gpio expected %h actual %h", cur_name, cur_gpio, gpio);
			bad = 1'b1;
		end
		if (bad)
			tests_failed++;
		else
			$display("PASS %0s", cur_name);
	endtask

	task automatic note_failure();
		other_errors++;
	endtask

endmodule

/* tb/tb_command.sv */
module tb_command
	import cmd_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk, reset;
	msg_byte_t msg_data;
	logic msg_ready, msg_rd_en;
	msg_byte_t send_ring_data;
	logic send_ring_wr_en, send_ring_full;
	rsp_len_t send_fifo_data;
	logic send_fifo_wr_en, send_fifo_full;
	arg_word_t systime;
	gpio_t gpio;

	msg_byte_t msg_q [$]; // host bytes not yet read by the DUT

	command u_dut (
		.clk(clk), .reset(reset),
		.msg_data(msg_data), .msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.send_ring_full(send_ring_full), .send_fifo_full(send_fifo_full),
		.send_ring_wr_en(send_ring_wr_en), .send_fifo_wr_en(send_fifo_wr_en),
		.send_ring_data(send_ring_data), .send_fifo_data(send_fifo_data),
		.systime(systime), .gpio(gpio)
	);

	command_checker u_checker (
		.clk(clk), .reset(reset),
		.msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en),
		.gpio(gpio)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// input FIFO model, the read pulse pops the head
	always @(posedge clk) begin
		if (msg_rd_en && msg_q.size() != 0)
			void'(msg_q.pop_front());
		msg_ready <= (msg_q.size() != 0);
		msg_data <= (msg_q.size() != 0) ? msg_q[0] : 8'h00;
	end

	// --------------------
	initial begin
		int fd, nin, full, nexp, stretch, wait_cnt, i, bad_total;
		logic [8*16-1:0] name;
		logic [7:0] in_b [6];
		logic [7:0] ex_b [6];
		logic [31:0] st;
		logic [7:0] egpio;
		logic [47:0] exp_bytes;

		void'($urandom(64441));
		reset = 1'b1;
		msg_data = 8'h00;
		msg_ready = 1'b0;
		send_ring_full = 1'b0;
		send_fifo_full = 1'b0;
		systime = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		fd = $fopen("tb/command_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/command_input.txt");
			u_checker.note_failure();
		end else begin
			while ($fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name, nin, in_b[0], in_b[1], in_b[2], in_b[3], in_b[4], in_b[5],
					st, full, nexp, ex_b[0], ex_b[1], ex_b[2], ex_b[3], ex_b[4], ex_b[5],
					egpio) == 18) begin
				exp_bytes = {ex_b[5], ex_b[4], ex_b[3], ex_b[2], ex_b[1], ex_b[0]};
				@(negedge clk);
				u_checker.start_test(name, nexp, exp_bytes, egpio);
				@(posedge clk);
				systime <= st;
				send_ring_full <= (full != 0); // ring stays full through the first byte
				@(negedge clk);
				for (i = 0; i < nin; i++)
					msg_q.push_back(in_b[i]);

				wait_cnt = 0;
				while (msg_q.size() != 0 && wait_cnt < 100) begin
					@(negedge clk);
					wait_cnt++;
				end
				if (msg_q.size() != 0) begin
					$display("%0s: the DUT stopped reading the input bytes", name);
					u_checker.note_failure();
					msg_q.delete();
				end

				if (full != 0) begin
					stretch = 12 + $urandom % 12;
					repeat (stretch) @(posedge clk);
					send_ring_full <= 1'b0;
				end

				if (nexp != 0) begin
					wait_cnt = 0;
					while (u_checker.fifo_writes == 0 && wait_cnt < 200) begin
						@(negedge clk);
						wait_cnt++;
					end
					if (u_checker.fifo_writes == 0) begin
						$display("%0s: no message length reached the send FIFO", name);
						u_checker.note_failure();
					end
				end
				repeat (10) @(negedge clk); // gpio settles within 8 cycles of the last read
				u_checker.finish_test();
				repeat ($urandom % 4) @(posedge clk); // gap before the next message
			end
			$fclose(fd);
		end

		bad_total = u_checker.tests_failed + u_checker.other_errors;
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			u_checker.tests_run, u_checker.tests_run - u_checker.tests_failed,
			u_checker.tests_failed, u_checker.other_errors);
		if (bad_total == 0 && u_checker.tests_run != 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* tb/command_input.txt */
version 1 00 00 00 00 00 00 00000000 0 3 00 90 34 00 00 00 00
time_small 1 02 00 00 00 00 00 00000005 0 2 01 05 00 00 00 00 00
time_neg 1 02 00 00 00 00 00 fffffff0 0 2 01 70 00 00 00 00 00
time_wide 1 02 00 00 00 00 00 00001234 0 3 01 a4 34 00 00 00 00
time_neg_wide 1 02 00 00 00 00 00 ffffff38 0 3 01 fe 38 00 00 00 00
set_on 3 0f 03 01 00 00 00 00000000 0 0 00 00 00 00 00 00 08
set_off 4 0f 03 82 00 00 00 00000000 0 0 00 00 00 00 00 00 00
set_neg 3 0f 05 7f 00 00 00 00000000 0 0 00 00 00 00 00 00 20
version_full 1 00 00 00 00 00 00 00000000 1 3 00 90 34 00 00 00 20
unknown_id 2 1e 00 00 00 00 00 00000000 0 3 00 90 34 00 00 00 20
shutdown 1 13 00 00 00 00 00 00000000 0 0 00 00 00 00 00 00 00
set_blocked 3 0f 03 01 00 00 00 00000000 0 0 00 00 00 00 00 00 00
time_late 1 02 00 00 00 00 00 0000002a 0 2 01 2a 00 00 00 00 00

/* filelist.f */
+incdir+logic
logic/cmd_pkg.sv
logic/vlq_decoder.sv
logic/cmd_dispatch.sv
logic/vlq_encoder.sv
logic/system_unit.sv
logic/gpio_unit.sv
logic/command.sv
tb/command_checker.sv
tb/tb_command.sv
